/* gpu_pkg.sv */
// Shared types and constants for the AXI-Lite drawing engine
// Every RTL module takes what it needs from here by wildcard import
package gpu_pkg;

    // ====================
    // Plain vector types
    typedef logic [31:0] axi_data_t;   // Bus and register word
    typedef logic [5:0]  reg_index_t;  // Word index, address bits 7:2
    typedef logic [15:0] coord_t;      // One x or y coordinate
    typedef logic [7:0]  color_t;      // Pixel value
    typedef logic [7:0]  cmd_code_t;   // Command byte

    // Command sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_RECT,
        ST_LINE,
        ST_PIXEL,
        ST_FINISH
    } cmd_state_t;

    // ====================
    // Command codes
    localparam cmd_code_t CMD_NOP        = 8'h00;
    localparam cmd_code_t CMD_CLEAR      = 8'h01;
    localparam cmd_code_t CMD_FILL_RECT  = 8'h02;
    localparam cmd_code_t CMD_DRAW_LINE  = 8'h03;
    localparam cmd_code_t CMD_DRAW_PIXEL = 8'h04;

    // Register map, byte address is index times 4
    localparam reg_index_t REG_ID      = 6'h00;
    localparam reg_index_t REG_STATUS  = 6'h01;
    localparam reg_index_t REG_CMD     = 6'h03;
    localparam reg_index_t REG_ARG0    = 6'h04;  // Start point, y in high half
    localparam reg_index_t REG_ARG1    = 6'h05;  // End point
    localparam reg_index_t REG_COLOR   = 6'h08;
    localparam reg_index_t REG_FB_READ = 6'h10;  // Linear pixel index to read
    localparam reg_index_t REG_FB_DATA = 6'h11;

    localparam axi_data_t GPU_ID        = 32'hABCD1234;
    localparam axi_data_t UNMAPPED_DATA = 32'hDEADBEEF;

endpackage

/* axi_lite_slave.sv */
`timescale 1ns/1ps
// AXI4-Lite slave front end of the drawing engine
// Turns bus writes into one-cycle register strobes and serves one read at a time
module axi_lite_slave
    import gpu_pkg::*;
(
    input  logic        S_AXI_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic [31:0] S_AXI_AWADDR,
    input  logic        S_AXI_AWVALID,
    output logic        S_AXI_AWREADY,
    input  logic [31:0] S_AXI_WDATA,
    input  logic [3:0]  S_AXI_WSTRB,
    input  logic        S_AXI_WVALID,
    output logic        S_AXI_WREADY,
    output logic [1:0]  S_AXI_BRESP,
    output logic        S_AXI_BVALID,
    input  logic        S_AXI_BREADY,
    input  logic [31:0] S_AXI_ARADDR,
    input  logic        S_AXI_ARVALID,
    output logic        S_AXI_ARREADY,
    output logic [31:0] S_AXI_RDATA,
    output logic [1:0]  S_AXI_RRESP,
    output logic        S_AXI_RVALID,
    input  logic        S_AXI_RREADY,
    output logic        wr_strobe,
    output reg_index_t  wr_index,
    output axi_data_t   wr_data,
    output reg_index_t  rd_index,
    input  axi_data_t   rd_data
);

    logic       aw_done;
    logic       w_done;
    logic [3:0] w_strb;
    logic       write_fire;

    // ==================== Write side
    // Address and data are taken independently, each held until B completes
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_AWREADY <= 1'b0;
            S_AXI_WREADY  <= 1'b0;
            S_AXI_BVALID  <= 1'b0;
            aw_done       <= 1'b0;
            w_done        <= 1'b0;
        end else begin
            S_AXI_AWREADY <= !aw_done && !S_AXI_AWREADY && S_AXI_AWVALID;
            S_AXI_WREADY  <= !w_done && !S_AXI_WREADY && S_AXI_WVALID;

            if (S_AXI_BVALID && S_AXI_BREADY) begin
                aw_done      <= 1'b0;  // Response done, open for the next write
                w_done       <= 1'b0;
                S_AXI_BVALID <= 1'b0;
            end else begin
                if (S_AXI_AWVALID && S_AXI_AWREADY) aw_done <= 1'b1;
                if (S_AXI_WVALID && S_AXI_WREADY)   w_done <= 1'b1;
                if (write_fire) S_AXI_BVALID <= 1'b1;
            end
        end
    end

    // Payload capture
    always_ff @(posedge S_AXI_ACLK) begin
        if (S_AXI_AWVALID && S_AXI_AWREADY) wr_index <= S_AXI_AWADDR[7:2];
        if (S_AXI_WVALID && S_AXI_WREADY) begin
            wr_data <= S_AXI_WDATA;
            w_strb  <= S_AXI_WSTRB;
        end
    end

    assign write_fire = aw_done && w_done && !S_AXI_BVALID;
    assign wr_strobe  = write_fire && (w_strb != 4'b0000);  // No lanes, no effect
    assign S_AXI_BRESP = 2'b00;

    // ==================== Read side
    // Index is latched as ARREADY goes up, so data is ready in the ARREADY cycle
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_ARREADY <= 1'b0;
            S_AXI_RVALID  <= 1'b0;
        end else begin
            S_AXI_ARREADY <= !S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;
            if (S_AXI_ARREADY && S_AXI_ARVALID) begin
                S_AXI_RVALID <= 1'b1;
            end else if (S_AXI_RREADY) begin
                S_AXI_RVALID <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID) rd_index <= S_AXI_ARADDR[7:2];
        if (S_AXI_ARREADY && S_AXI_ARVALID) S_AXI_RDATA <= rd_data;
    end

    assign S_AXI_RRESP = 2'b00;  // Always OKAY

endmodule

/* gpu_regs.sv */
`timescale 1ns/1ps
// Register file of the drawing engine
// Takes write strobes from the bus slave, muxes read data and raises the start strobe
module gpu_regs
    import gpu_pkg::*;
(
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,
    input  logic       wr_strobe,
    input  reg_index_t wr_index,
    input  axi_data_t  wr_data,
    input  reg_index_t rd_index,
    output axi_data_t  rd_data,
    output logic       start,
    output cmd_code_t  cmd,
    output coord_t     x0,
    output coord_t     y0,
    output coord_t     x1,
    output coord_t     y1,
    output color_t     color,
    output axi_data_t  fb_rd_addr,
    input  logic       busy,
    input  logic       done,
    input  color_t     fb_pixel
);

    axi_data_t arg0;
    axi_data_t arg1;

    // ==================== Write decode
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            start      <= 1'b0;
            cmd        <= CMD_NOP;
            arg0       <= '0;
            arg1       <= '0;
            color      <= 8'hFF;
            fb_rd_addr <= '0;
        end else begin
            // One-cycle pulse, NOP never starts anything
            start <= wr_strobe && (wr_index == REG_CMD) && (wr_data[7:0] != CMD_NOP);
            if (wr_strobe) begin
                case (wr_index)
                    REG_CMD:     cmd <= wr_data[7:0];
                    REG_ARG0:    arg0 <= wr_data;
                    REG_ARG1:    arg1 <= wr_data;
                    REG_COLOR:   color <= wr_data[7:0];
                    REG_FB_READ: fb_rd_addr <= wr_data;
                    default:     ;  // Read-only or unmapped
                endcase
            end
        end
    end

    // Points packed as y:x
    assign x0 = arg0[15:0];
    assign y0 = arg0[31:16];
    assign x1 = arg1[15:0];
    assign y1 = arg1[31:16];

    // ==================== Read mux
    always_comb begin
        case (rd_index)
            REG_ID:      rd_data = GPU_ID;
            REG_STATUS:  rd_data = {30'b0, done, busy};
            REG_CMD:     rd_data = {24'b0, cmd};
            REG_ARG0:    rd_data = arg0;
            REG_ARG1:    rd_data = arg1;
            REG_COLOR:   rd_data = {24'b0, color};
            REG_FB_READ: rd_data = fb_rd_addr;
            REG_FB_DATA: rd_data = {24'b0, fb_pixel};
            default:     rd_data = UNMAPPED_DATA;
        endcase
    end

endmodule

/* gpu_cmd_fsm.sv */
`timescale 1ns/1ps
// Command sequencer of the drawing engine
// Decodes a started command, drives the walkers and writes one pixel per cycle
module gpu_cmd_fsm
    import gpu_pkg::*;
#(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 200
) (
    input  logic      S_AXI_ACLK,
    input  logic      S_AXI_ARESETN,
    input  logic      start,
    input  cmd_code_t cmd,
    input  coord_t    x0,
    input  coord_t    y0,
    input  coord_t    x1,
    input  coord_t    y1,
    input  color_t    color,
    output logic      busy,
    output logic      done,
    output logic      scan_load,
    output logic      scan_step,
    output coord_t    scan_x_lo,
    output coord_t    scan_y_lo,
    output coord_t    scan_x_hi,
    output coord_t    scan_y_hi,
    input  coord_t    scan_x,
    input  coord_t    scan_y,
    input  logic      scan_last,
    output logic      line_load,
    output logic      line_step,
    input  coord_t    line_x,
    input  coord_t    line_y,
    input  logic      line_at_end,
    output logic      pix_we,
    output coord_t    pix_x,
    output coord_t    pix_y,
    output color_t    pix_color
);

    cmd_state_t state;
    logic       accept;
    logic       is_clear;

    assign accept   = (state == ST_IDLE) && start;  // Starts while busy are dropped
    assign is_clear = (cmd == CMD_CLEAR);

    // ==================== State register
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= ST_IDLE;
            done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        done <= 1'b0;
                        case (cmd)
                            CMD_CLEAR:      state <= ST_CLEAR;
                            CMD_FILL_RECT:  state <= ST_RECT;
                            CMD_DRAW_LINE:  state <= ST_LINE;
                            CMD_DRAW_PIXEL: state <= ST_PIXEL;
                            default:        state <= ST_FINISH;  // Unknown code
                        endcase
                    end
                end
                ST_CLEAR, ST_RECT: if (scan_last) state <= ST_FINISH;
                ST_LINE:           if (line_at_end) state <= ST_FINISH;
                ST_PIXEL:          state <= ST_FINISH;
                ST_FINISH: begin
                    done  <= 1'b1;  // Sticky until the next start
                    state <= ST_IDLE;
                end
                default:           state <= ST_IDLE;
            endcase
        end
    end

    // Color is held for the whole command
    always_ff @(posedge S_AXI_ACLK) begin
        if (accept) pix_color <= color;
    end

    assign busy = (state != ST_IDLE) && (state != ST_FINISH);

    // ==================== Walker control
    assign scan_load = accept && (is_clear || cmd == CMD_FILL_RECT);
    assign scan_x_lo = is_clear ? '0 : x0;
    assign scan_y_lo = is_clear ? '0 : y0;
    assign scan_x_hi = is_clear ? coord_t'(FB_WIDTH - 1) : x1;
    assign scan_y_hi = is_clear ? coord_t'(FB_HEIGHT - 1) : y1;
    assign scan_step = (state == ST_CLEAR) || (state == ST_RECT);

    assign line_load = accept && (cmd == CMD_DRAW_LINE);
    assign line_step = (state == ST_LINE);

    // Pixel write port
    always_comb begin
        pix_we = 1'b1;
        case (state)
            ST_CLEAR, ST_RECT: begin
                pix_x = scan_x;
                pix_y = scan_y;
            end
            ST_LINE: begin
                pix_x = line_x;
                pix_y = line_y;
            end
            ST_PIXEL: begin
                pix_x = x0;
                pix_y = y0;
            end
            default: begin
                pix_we = 1'b0;
                pix_x  = x0;
                pix_y  = y0;
            end
        endcase
    end

endmodule

/* raster_counter.sv */
`timescale 1ns/1ps
// Two-dimensional scan counter for clear and rectangle fill
// Loaded with inclusive limits, walks x fastest and holds at the last point
module raster_counter
    import gpu_pkg::*;
#(
    parameter int FB_WIDTH = 320
) (
    input  logic   S_AXI_ACLK,
    input  logic   load,
    input  logic   step,
    input  coord_t x_lo,
    input  coord_t y_lo,
    input  coord_t x_hi,
    input  coord_t y_hi,
    output coord_t x,
    output coord_t y,
    output logic   last
);

    localparam coord_t X_MAX = coord_t'(FB_WIDTH - 1);

    coord_t x_first;  // Row start to wrap back to
    coord_t x_stop;
    coord_t y_stop;
    logic   row_end;

    assign row_end = (x >= x_stop);
    assign last    = row_end && (y >= y_stop);

    always_ff @(posedge S_AXI_ACLK) begin
        if (load) begin
            x       <= x_lo;
            y       <= y_lo;
            x_first <= x_lo;
            x_stop  <= (x_hi > X_MAX) ? X_MAX : x_hi;  // No cycles spent off the right edge
            y_stop  <= y_hi;
        end else if (step && !last) begin
            if (row_end) begin
                x <= x_first;
                y <= y + 16'd1;
            end else begin
                x <= x + 16'd1;
            end
        end
    end

endmodule

/* line_stepper.sv */
`timescale 1ns/1ps
// Line position register for the draw-line command
// Each step moves both axes one unit toward the end, so lines go diagonal then straight
module line_stepper
    import gpu_pkg::*;
(
    input  logic   S_AXI_ACLK,
    input  logic   load,
    input  logic   step,
    input  coord_t x_start,
    input  coord_t y_start,
    input  coord_t x_end,
    input  coord_t y_end,
    output coord_t x,
    output coord_t y,
    output logic   at_end
);

    coord_t x_goal;
    coord_t y_goal;

    assign at_end = (x == x_goal) && (y == y_goal);

    always_ff @(posedge S_AXI_ACLK) begin
        if (load) begin
            x      <= x_start;
            y      <= y_start;
            x_goal <= x_end;
            y_goal <= y_end;
        end else if (step) begin
            // Axis already on target stays put
            if (x < x_goal) x <= x + 16'd1;
            else if (x > x_goal) x <= x - 16'd1;

            if (y < y_goal) y <= y + 16'd1;
            else if (y > y_goal) y <= y - 16'd1;
        end
    end

endmodule

/* framebuffer.sv */
`timescale 1ns/1ps
// Pixel memory with x/y write port and linear registered read port
// Writes outside the frame are dropped here and nowhere else
module framebuffer
    import gpu_pkg::*;
#(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 200
) (
    input  logic      S_AXI_ACLK,
    input  logic      we,
    input  coord_t    x,
    input  coord_t    y,
    input  color_t    din,
    input  axi_data_t rd_addr,
    output color_t    rd_pixel
);

    localparam int NUM_PIX = FB_WIDTH * FB_HEIGHT;
    localparam int ADDR_W  = $clog2(NUM_PIX);

    typedef logic [ADDR_W-1:0] fb_addr_t;

    color_t   mem [NUM_PIX];
    logic     in_frame;
    fb_addr_t wr_addr;

    assign in_frame = (x < FB_WIDTH) && (y < FB_HEIGHT);
    assign wr_addr  = fb_addr_t'(y * FB_WIDTH + x);  // Row-major

    always_ff @(posedge S_AXI_ACLK) begin
        if (we && in_frame) mem[wr_addr] <= din;
    end

    // Out-of-range reads return black
    always_ff @(posedge S_AXI_ACLK) begin
        rd_pixel <= (rd_addr < NUM_PIX) ? mem[rd_addr[ADDR_W-1:0]] : '0;
    end

endmodule

/* gpu_top.sv */
`timescale 1ns/1ps
// Top level of the AXI-Lite drawing engine
// Wires the bus slave, registers, sequencer, walkers and framebuffer together
module gpu_top
    import gpu_pkg::*;
#(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 200
) (
    input  logic        S_AXI_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic [31:0] S_AXI_AWADDR,
    input  logic        S_AXI_AWVALID,
    output logic        S_AXI_AWREADY,
    input  logic [31:0] S_AXI_WDATA,
    input  logic [3:0]  S_AXI_WSTRB,
    input  logic        S_AXI_WVALID,
    output logic        S_AXI_WREADY,
    output logic [1:0]  S_AXI_BRESP,
    output logic        S_AXI_BVALID,
    input  logic        S_AXI_BREADY,
    input  logic [31:0] S_AXI_ARADDR,
    input  logic        S_AXI_ARVALID,
    output logic        S_AXI_ARREADY,
    output logic [31:0] S_AXI_RDATA,
    output logic [1:0]  S_AXI_RRESP,
    output logic        S_AXI_RVALID,
    input  logic        S_AXI_RREADY
);

    // ==================== Interconnect
    logic       wr_strobe;
    reg_index_t wr_index;
    axi_data_t  wr_data;
    reg_index_t rd_index;
    axi_data_t  rd_data;

    logic      start, busy, done;
    cmd_code_t cmd;
    coord_t    x0, y0, x1, y1;
    color_t    color;
    axi_data_t fb_rd_addr;
    color_t    fb_pixel;

    logic   scan_load, scan_step, scan_last;
    coord_t scan_x_lo, scan_y_lo, scan_x_hi, scan_y_hi;
    coord_t scan_x, scan_y;

    logic   line_load, line_step, line_at_end;
    coord_t line_x, line_y;

    logic   pix_we;
    coord_t pix_x, pix_y;
    color_t pix_color;

    // ==================== Instances
    axi_lite_slave u_axi (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WSTRB   (S_AXI_WSTRB),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .wr_strobe     (wr_strobe),
        .wr_index      (wr_index),
        .wr_data       (wr_data),
        .rd_index      (rd_index),
        .rd_data       (rd_data)
    );

    gpu_regs u_regs (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_strobe     (wr_strobe),
        .wr_index      (wr_index),
        .wr_data       (wr_data),
        .rd_index      (rd_index),
        .rd_data       (rd_data),
        .start         (start),
        .cmd           (cmd),
        .x0            (x0),
        .y0            (y0),
        .x1            (x1),
        .y1            (y1),
        .color         (color),
        .fb_rd_addr    (fb_rd_addr),
        .busy          (busy),
        .done          (done),
        .fb_pixel      (fb_pixel)
    );

    gpu_cmd_fsm #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_fsm (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .start         (start),
        .cmd           (cmd),
        .x0            (x0),
        .y0            (y0),
        .x1            (x1),
        .y1            (y1),
        .color         (color),
        .busy          (busy),
        .done          (done),
        .scan_load     (scan_load),
        .scan_step     (scan_step),
        .scan_x_lo     (scan_x_lo),
        .scan_y_lo     (scan_y_lo),
        .scan_x_hi     (scan_x_hi),
        .scan_y_hi     (scan_y_hi),
        .scan_x        (scan_x),
        .scan_y        (scan_y),
        .scan_last     (scan_last),
        .line_load     (line_load),
        .line_step     (line_step),
        .line_x        (line_x),
        .line_y        (line_y),
        .line_at_end   (line_at_end),
        .pix_we        (pix_we),
        .pix_x         (pix_x),
        .pix_y         (pix_y),
        .pix_color     (pix_color)
    );

    raster_counter #(
        .FB_WIDTH (FB_WIDTH)
    ) u_scan (
        .S_AXI_ACLK (S_AXI_ACLK),
        .load       (scan_load),
        .step       (scan_step),
        .x_lo       (scan_x_lo),
        .y_lo       (scan_y_lo),
        .x_hi       (scan_x_hi),
        .y_hi       (scan_y_hi),
        .x          (scan_x),
        .y          (scan_y),
        .last       (scan_last)
    );

    line_stepper u_line (
        .S_AXI_ACLK (S_AXI_ACLK),
        .load       (line_load),
        .step       (line_step),
        .x_start    (x0),
        .y_start    (y0),
        .x_end      (x1),
        .y_end      (y1),
        .x          (line_x),
        .y          (line_y),
        .at_end     (line_at_end)
    );

    framebuffer #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_fb (
        .S_AXI_ACLK (S_AXI_ACLK),
        .we         (pix_we),
        .x          (pix_x),
        .y          (pix_y),
        .din        (pix_color),
        .rd_addr    (fb_rd_addr),
        .rd_pixel   (fb_pixel)
    );

endmodule

/* tb_gpu.sv */
`timescale 1ns/1ps
// Directed testbench for the AXI-Lite drawing engine on a 16 by 12 frame
// Drives registers over AXI and compares read-back pixels with a pixel model
module tb_gpu
    import gpu_pkg::*;
();

    localparam int W       = 16;
    localparam int H       = 12;
    localparam int NUM_PIX = W * H;
    // Pixel readbacks come to just over three frames at about 8 cycles a pixel
    // Four frames of that, plus drawing time and margin
    localparam int CYCLE_LIMIT = 4 * NUM_PIX * 8 + 4 * NUM_PIX + 1000;

    logic        S_AXI_ACLK;
    logic        S_AXI_ARESETN;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    color_t      model [NUM_PIX];          // Expected frame contents
    logic [31:0] lfsr_state = 32'hb23b_3054;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;

    gpu_top #(
        .FB_WIDTH  (W),
        .FB_HEIGHT (H)
    ) DUT (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (awaddr),
        .S_AXI_AWVALID (awvalid),
        .S_AXI_AWREADY (awready),
        .S_AXI_WDATA   (wdata),
        .S_AXI_WSTRB   (wstrb),
        .S_AXI_WVALID  (wvalid),
        .S_AXI_WREADY  (wready),
        .S_AXI_BRESP   (bresp),
        .S_AXI_BVALID  (bvalid),
        .S_AXI_BREADY  (bready),
        .S_AXI_ARADDR  (araddr),
        .S_AXI_ARVALID (arvalid),
        .S_AXI_ARREADY (arready),
        .S_AXI_RDATA   (rdata),
        .S_AXI_RRESP   (rresp),
        .S_AXI_RVALID  (rvalid),
        .S_AXI_RREADY  (rready)
    );

    always #2 S_AXI_ACLK = ~S_AXI_ACLK;  // 4 ns period

    always @(posedge S_AXI_ACLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: no result after %0d clock cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // ==================== Helpers
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic logic [31:0] pack_point(input int x, input int y);
        return {y[15:0], x[15:0]};  // y in the high half
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", what, got, exp);
            error_count++;
        end
    endtask

    // ==================== Pixel model
    function automatic void model_pixel(input int x, input int y, input color_t c);
        if (x >= 0 && x < W && y >= 0 && y < H) model[y * W + x] = c;  // Off-frame dropped
    endfunction

    function automatic void model_fill(input int x0, input int y0, input int x1,
                                       input int y1, input color_t c);
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) model_pixel(x, y, c);
        end
    endfunction

    // One unit per axis per step, so diagonal first, then straight
    function automatic void model_line(input int x0, input int y0, input int x1,
                                       input int y1, input color_t c);
        int x;
        int y;
        x = x0;
        y = y0;
        model_pixel(x, y, c);
        while (x != x1 || y != y1) begin
            if (x < x1) x++;
            else if (x > x1) x--;
            if (y < y1) y++;
            else if (y > y1) y--;
            model_pixel(x, y, c);
        end
    endfunction

    // ==================== AXI access, called on a falling edge
    task automatic axi_write(input reg_index_t idx, input logic [31:0] data);
        logic aw_hs;
        logic w_hs;
        awaddr  = {24'b0, idx, 2'b00};
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        while (awvalid || wvalid) begin
            aw_hs = awvalid && awready;  // Taken at the coming rising edge
            w_hs  = wvalid && wready;
            @(negedge S_AXI_ACLK);
            if (aw_hs) awvalid = 1'b0;
            if (w_hs) wvalid = 1'b0;
        end
        while (!bvalid) @(negedge S_AXI_ACLK);
        check_equal("S_AXI_BRESP", 32'(bresp), 32'h0);
        @(negedge S_AXI_ACLK);
        bready = 1'b0;
    endtask

    task automatic axi_read(input reg_index_t idx, output logic [31:0] data);
        araddr  = {24'b0, idx, 2'b00};
        arvalid = 1'b1;
        rready  = 1'b1;
        while (arvalid) begin
            if (arready) begin
                @(negedge S_AXI_ACLK);
                arvalid = 1'b0;
            end else begin
                @(negedge S_AXI_ACLK);
            end
        end
        while (!rvalid) @(negedge S_AXI_ACLK);
        data = rdata;
        check_equal("S_AXI_RRESP", 32'(rresp), 32'h0);
        @(negedge S_AXI_ACLK);
        rready = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        axi_read(REG_STATUS, status);
        while (status[0]) axi_read(REG_STATUS, status);  // Bit 0 is busy
    endtask

    task automatic run_command(input cmd_code_t code);
        axi_write(REG_CMD, {24'b0, code});
        wait_idle();
    endtask

    task automatic check_pixel(input int idx);
        logic [31:0] d;
        axi_write(REG_FB_READ, idx);
        axi_read(REG_FB_DATA, d);
        check_equal($sformatf("REG_FB_DATA pixel (%0d,%0d)", idx % W, idx / W),
                    d, {24'b0, model[idx]});
    endtask

    task automatic check_frame();
        for (int i = 0; i < NUM_PIX; i++) check_pixel(i);
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s, %0d errors", name, error_count - errors_before);
        end
    endtask

    // ==================== Tests
    task automatic test_registers();
        int          e;
        logic [31:0] d;
        e = error_count;
        axi_read(REG_STATUS, d);
        check_equal("REG_STATUS after reset", d, 32'h0);
        axi_read(REG_COLOR, d);
        check_equal("REG_COLOR after reset", d, 32'hFF);
        axi_read(REG_ID, d);
        check_equal("REG_ID", d, 32'hABCD1234);
        axi_write(REG_COLOR, 32'h42);
        axi_read(REG_COLOR, d);
        check_equal("REG_COLOR", d, 32'h42);
        axi_write(REG_ARG0, 32'h0007_0003);
        axi_read(REG_ARG0, d);
        check_equal("REG_ARG0", d, 32'h0007_0003);
        axi_write(REG_ARG1, 32'h000B_000E);
        axi_read(REG_ARG1, d);
        check_equal("REG_ARG1", d, 32'h000B_000E);
        axi_read(6'h3C, d);  // Nothing mapped here
        check_equal("unmapped register", d, 32'hDEADBEEF);
        end_test("register access", e);
    endtask

    task automatic test_clear();
        int          e;
        logic [31:0] d;
        e = error_count;
        axi_write(REG_COLOR, 32'h1E);
        run_command(CMD_CLEAR);
        model_fill(0, 0, W - 1, H - 1, 8'h1E);
        axi_read(REG_STATUS, d);
        check_equal("REG_STATUS after clear", d, 32'h2);  // Done set, busy clear
        repeat (20) check_pixel(random_bits(8) % NUM_PIX);
        end_test("clear", e);
    endtask

    task automatic test_pixels();
        int     e;
        int     x;
        int     y;
        color_t c;
        e = error_count;
        for (int i = 0; i < 6; i++) begin
            x = random_bits(4);
            y = random_bits(4) % H;
            c = color_t'(8'h80 + i);
            axi_write(REG_COLOR, {24'b0, c});
            axi_write(REG_ARG0, pack_point(x, y));
            run_command(CMD_DRAW_PIXEL);
            model_pixel(x, y, c);
            check_pixel(y * W + x);
        end
        // Off the right edge, a wrapped address would hit (4,6)
        axi_write(REG_COLOR, 32'hEE);
        axi_write(REG_ARG0, pack_point(20, 5));
        run_command(CMD_DRAW_PIXEL);
        model_pixel(20, 5, 8'hEE);
        check_pixel(6 * W + 4);
        check_pixel(5 * W + 15);
        end_test("draw pixel", e);
    endtask

    task automatic test_rect();
        int e;
        e = error_count;
        axi_write(REG_COLOR, 32'h3C);
        axi_write(REG_ARG0, pack_point(10, 3));
        axi_write(REG_ARG1, pack_point(20, 7));  // Runs past x = 15
        run_command(CMD_FILL_RECT);
        model_fill(10, 3, 20, 7, 8'h3C);
        check_frame();
        end_test("fill rectangle", e);
    endtask

    task automatic test_line();
        int e;
        e = error_count;
        axi_write(REG_COLOR, 32'hA5);
        axi_write(REG_ARG0, pack_point(2, 1));
        axi_write(REG_ARG1, pack_point(9, 4));
        run_command(CMD_DRAW_LINE);
        model_line(2, 1, 9, 4, 8'hA5);
        check_frame();
        end_test("draw line", e);
    endtask

    task automatic test_busy_command();
        int          e;
        logic [31:0] d;
        e = error_count;
        axi_write(REG_COLOR, 32'h5A);
        axi_write(REG_ARG0, pack_point(0, 11));
        axi_write(REG_ARG1, pack_point(15, 0));
        axi_write(REG_CMD, {24'b0, CMD_DRAW_LINE});
        axi_write(REG_CMD, {24'b0, CMD_CLEAR});  // Lands in the middle of the line
        axi_read(REG_STATUS, d);
        assert (d[0]) else begin
            $display("Line finished before the second command could be issued");
            error_count++;
        end
        wait_idle();
        model_line(0, 11, 15, 0, 8'h5A);
        check_frame();
        end_test("command while busy", e);
    endtask

    // ==================== Main sequence
    initial begin
        S_AXI_ACLK    = 1'b0;
        S_AXI_ARESETN = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'h0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int i = 0; i < NUM_PIX; i++) model[i] = 8'h00;

        repeat (4) @(posedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        @(negedge S_AXI_ACLK);

        test_registers();
        test_clear();
        test_pixels();
        test_rect();
        test_line();
        test_busy_command();

        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* build.f */
gpu_pkg.sv
axi_lite_slave.sv
gpu_regs.sv
gpu_cmd_fsm.sv
raster_counter.sv
line_stepper.sv
framebuffer.sv
gpu_top.sv
tb_gpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the drawing engine testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_gpu -f build.f -o Vtb_gpu

./obj_dir/Vtb_gpu | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
